/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = dekatronTapeTb
FILELIST = dekatronTape.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir $(LOG)

/* dekatronTape.f */
+incdir+rtl
rtl/dekatronPkg.sv
rtl/dekatronIf.sv
rtl/dekatronCounter.sv
rtl/tapeMemory.sv
rtl/commandDecoder.sv
rtl/apLine.sv
rtl/outputPort.sv
rtl/dekatronTape.sv
dv/dekatronTapeTb.sv

/* dv/dekatronTapeTb.sv */
`default_nettype none

`include "dekatron_macros.svh"

module dekatronTapeTb
    import dekatronPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int opCycles = 2 * `STEP_CYCLES + 8;
    localparam int opBudget = 400;
    localparam int timeoutCycles = 8 + opBudget * opCycles;

    logic Clk;
    logic Rst_n;
    opcodeT Op;
    logic OpValid;
    cellT InData;
    logic Ready;
    logic OutValid;
    logic DataZero;
    logic ApZero;
    cellT OutData;

    // reference tape and pointer, plain integers.
    int tape [`TAPE_CELLS];
    int ptr;
    int outPulses;
    int outExpected;

    dekatronTape dekatronTape_i (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .Op(Op),
        .OpValid(OpValid),
        .InData(InData),
        .Ready(Ready),
        .OutValid(OutValid),
        .DataZero(DataZero),
        .ApZero(ApZero),
        .OutData(OutData)
    );

    always #4 Clk = ~Clk;

    always @(posedge Clk) begin
        if (OutValid) begin
            outPulses = outPulses + 1;
        end
    end

    function automatic cellT bcdOf(input int value);
        return {4'(value / 100), 4'(value / 10 % 10), 4'(value % 10)};
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkCell(input string name, input cellT got, input cellT expected);
        if (got !== expected) begin
            failRun($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            failRun($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic waitReady();
        int cycles;
        cycles = 0;
        while (Ready !== 1'b1) begin
            if (cycles == opCycles) begin
                failRun("the tape did not return to ready after an opcode");
            end
            @(posedge Clk);
            #1;
            cycles++;
        end
    endtask

    // called 1 ns after a rising edge, returns at the same phase.
    task automatic doOp(input opcodeT op, input cellT data);
        Op = op;
        InData = data;
        OpValid = 1'b1;
        @(posedge Clk);
        #1;
        OpValid = 1'b0;
        // only outCell leaves Ready high right after the edge.
        checkFlag("Ready", Ready, op == outCell);
        waitReady();
    endtask

    task automatic checkOutput(input cellT expected);
        int cycles;
        cycles = 0;
        while (OutValid !== 1'b1) begin
            if (cycles == 4) begin
                failRun("no OutValid pulse followed the outCell opcode");
            end
            @(posedge Clk);
            #1;
            cycles++;
        end
        checkCell("OutData", OutData, expected);
        outExpected++;
        @(posedge Clk);
        #1;
        checkFlag("OutValid", OutValid, 1'b0);
    endtask

    task automatic runOp(input opcodeT op, input int value);
        doOp(op, bcdOf(value));
        case (op)
            incPtr: ptr = (ptr + 1) % `TAPE_CELLS;
            decPtr: ptr = (ptr + `TAPE_CELLS - 1) % `TAPE_CELLS;
            incCell: tape[ptr] = (tape[ptr] == `DATA_TOP) ? 0 : tape[ptr] + 1;
            decCell: tape[ptr] = (tape[ptr] == 0) ? `DATA_TOP : tape[ptr] - 1;
            clrCell: tape[ptr] = 0;
            inCell: tape[ptr] = value;
            outCell: checkOutput(bcdOf(tape[ptr]));
            default: failRun("an unknown opcode was issued");
        endcase
        checkFlag("ApZero", ApZero, ptr == 0);
        checkFlag("DataZero", DataZero, tape[ptr] == 0);
    endtask

    task automatic testReset();
        checkFlag("Ready", Ready, 1'b1);
        checkFlag("ApZero", ApZero, 1'b1);
        checkFlag("DataZero", DataZero, 1'b1);
        runOp(outCell, 0);
    endtask

    task automatic testCounting();
        repeat (12) runOp(incCell, 0);
        runOp(outCell, 0);
        repeat (5) runOp(decCell, 0);
        runOp(outCell, 0);
        repeat (7) runOp(decCell, 0);
        runOp(outCell, 0);
    endtask

    task automatic testWrap();
        runOp(inCell, `DATA_TOP);
        runOp(incCell, 0);
        runOp(outCell, 0);
        runOp(decCell, 0);
        runOp(outCell, 0);
    endtask

    // cell 0 holds 255 here, so every move back checks the store path.
    task automatic testPointer();
        runOp(incPtr, 0);
        runOp(inCell, 42);
        runOp(incCell, 0);
        runOp(decPtr, 0);
        runOp(outCell, 0);
        runOp(incPtr, 0);
        runOp(outCell, 0);
        runOp(decPtr, 0);
        runOp(decPtr, 0);
        runOp(outCell, 0);
        runOp(incCell, 0);
        runOp(incPtr, 0);
        runOp(outCell, 0);
        runOp(decPtr, 0);
        runOp(outCell, 0);
        runOp(incPtr, 0);
    endtask

    task automatic testLoadClear();
        runOp(inCell, 138);
        runOp(outCell, 0);
        runOp(clrCell, 0);
        runOp(outCell, 0);
        runOp(incPtr, 0);
        runOp(clrCell, 0);
        runOp(outCell, 0);
        runOp(inCell, 200);
        runOp(incPtr, 0);
        runOp(decPtr, 0);
        runOp(outCell, 0);
    endtask

    task automatic testRandom();
        opcodeT op;
        int value;
        for (int i = 0; i < 300; i++) begin
            op = opcodeT'($urandom % 7);
            value = $urandom % (`DATA_TOP + 1);
            runOp(op, value);
        end
    endtask

    initial begin
        Clk = 1'b0;
        Rst_n = 1'b0;
        Op = incPtr;
        OpValid = 1'b0;
        InData = '0;
        ptr = 0;
        outPulses = 0;
        outExpected = 0;
        for (int i = 0; i < `TAPE_CELLS; i++) begin
            tape[i] = 0;
        end
        void'($urandom(32'h8ac86b8e));
        repeat (8) @(posedge Clk);
        #1;
        Rst_n = 1'b1;
        testReset();
        testCounting();
        testWrap();
        testPointer();
        testLoadClear();
        testRandom();
        if (outPulses == outExpected) begin
            $display("Test OK");
            $finish;
        end else begin
            failRun("OutValid pulsed more often than outCell was issued");
        end
    end

    // budget covers every opcode of the run at its slowest.
    initial begin
        repeat (timeoutCycles) @(posedge Clk);
        failRun("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

/* rtl/apLine.sv */
`default_nettype none

`include "dekatron_macros.svh"

module apLine
    import dekatronPkg::*;
(
    input logic Clk,
    input logic Rst_n,
    input cellT InData,
    lineCmdIf.line cmd,
    tapeRamIf.line ram,
    output logic Ready,
    output logic DataZero,
    output logic ApZero,
    output cellT TxData
);

    function automatic cellT toBcd(input int unsigned number);
        cellT result;
        int unsigned rest;
        result = '0;
        rest = number;
        for (int i = 0; i < `DATA_DIGITS; i++) begin
            result[i*`DEKATRON_WIDTH +: `DEKATRON_WIDTH] = digitT'(rest % 10);
            rest = rest / 10;
        end
        return result;
    endfunction

    localparam cellT dataTopBcd = toBcd(`DATA_TOP);

    lineStateT state;
    logic locked;
    logic apReq;
    logic dataReq;
    logic dataSet;
    logic ramWe;
    logic decLatch;
    logic zeroLatch;

    counterIf #(.DIGITS(`AP_DIGITS)) apCnt ();
    counterIf #(.DIGITS(`DATA_DIGITS)) dataCnt ();

    // the pointer wraps on its own at 99.
    dekatronCounter #(
        .DIGITS(`AP_DIGITS),
        .TOP_LIMIT(1'b0)
    ) apCounter (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .cnt(apCnt.counter)
    );

    dekatronCounter #(
        .DIGITS(`DATA_DIGITS),
        .TOP_LIMIT(1'b1),
        .TOP_VALUE(dataTopBcd)
    ) dataCounter (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .cnt(dataCnt.counter)
    );

    assign apCnt.Request = apReq;
    assign apCnt.Dec = decLatch;
    assign apCnt.Set = 1'b0;
    assign apCnt.SetZero = 1'b0;
    assign apCnt.In = '0;

    assign dataCnt.Request = dataReq;
    assign dataCnt.Dec = decLatch;
    assign dataCnt.Set = dataSet;
    assign dataCnt.SetZero = zeroLatch && (state == count);
    assign dataCnt.In = (state == cin) ? InData : ram.DataOut;

    assign ram.Address = apCnt.Out;
    assign ram.DataIn = dataCnt.Out;
    assign ram.WE = ramWe;

    // a locked cell lives in the data counter, not in the tape.
    assign TxData = locked ? dataCnt.Out : ram.DataOut;
    assign DataZero = locked ? dataCnt.Zero : (ram.DataOut == '0);
    assign ApZero = apCnt.Zero;

    assign Ready = (state == idle) && apCnt.Ready && dataCnt.Ready
        && !cmd.ApRequest && !cmd.DataRequest;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state <= idle;
            locked <= 1'b0;
            apReq <= 1'b0;
            dataReq <= 1'b0;
            dataSet <= 1'b0;
            ramWe <= 1'b0;
            decLatch <= 1'b0;
            zeroLatch <= 1'b0;
        end else begin
            apReq <= 1'b0;
            dataReq <= 1'b0;
            dataSet <= 1'b0;
            ramWe <= 1'b0;
            case (state)
                idle: begin
                    if (cmd.ApRequest || cmd.DataRequest) begin
                        decLatch <= cmd.Dec;
                        zeroLatch <= cmd.Zero;
                    end
                    if (cmd.ApRequest) begin
                        if (locked) begin
                            ramWe <= 1'b1;
                            state <= store;
                        end else begin
                            apReq <= 1'b1;
                            state <= count;
                        end
                    end else if (cmd.DataRequest) begin
                        dataReq <= 1'b1;
                        if (cmd.Cin) begin
                            dataSet <= 1'b1;
                            locked <= 1'b1;
                            state <= cin;
                        end else if (!locked) begin
                            dataSet <= 1'b1;
                            locked <= 1'b1;
                            state <= load;
                        end else begin
                            state <= count;
                        end
                    end
                end
                // wait for the load pass, then step the fresh copy.
                load: begin
                    if (!dataReq && dataCnt.Ready) begin
                        dataReq <= 1'b1;
                        state <= count;
                    end
                end
                store: begin
                    locked <= 1'b0;
                    apReq <= 1'b1;
                    state <= count;
                end
                cin: begin
                    if (!dataReq && dataCnt.Ready) begin
                        state <= idle;
                    end
                end
                count: begin
                    if (!apReq && !dataReq && apCnt.Ready && dataCnt.Ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/commandDecoder.sv */
`default_nettype none

module commandDecoder
    import dekatronPkg::*;
(
    input logic Clk,
    input logic Rst_n,
    input opcodeT Op,
    input logic OpValid,
    input logic Ready,
    output logic OutStrobe,
    lineCmdIf.decoder cmd
);

    logic accept;
    logic apNext;
    logic dataNext;
    logic decNext;
    logic zeroNext;
    logic cinNext;
    logic outNext;

    assign accept = OpValid && Ready;

    always_comb begin
        apNext = 1'b0;
        dataNext = 1'b0;
        decNext = 1'b0;
        zeroNext = 1'b0;
        cinNext = 1'b0;
        outNext = 1'b0;
        if (accept) begin
            case (Op)
                incPtr: apNext = 1'b1;
                decPtr: begin
                    apNext = 1'b1;
                    decNext = 1'b1;
                end
                incCell: dataNext = 1'b1;
                decCell: begin
                    dataNext = 1'b1;
                    decNext = 1'b1;
                end
                clrCell: begin
                    dataNext = 1'b1;
                    zeroNext = 1'b1;
                end
                inCell: begin
                    dataNext = 1'b1;
                    cinNext = 1'b1;
                end
                outCell: outNext = 1'b1;
                default: outNext = 1'b0;
            endcase
        end
    end

    // every strobe lasts one cycle.
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            cmd.ApRequest <= 1'b0;
            cmd.DataRequest <= 1'b0;
            cmd.Dec <= 1'b0;
            cmd.Zero <= 1'b0;
            cmd.Cin <= 1'b0;
            OutStrobe <= 1'b0;
        end else begin
            cmd.ApRequest <= apNext;
            cmd.DataRequest <= dataNext;
            cmd.Dec <= decNext;
            cmd.Zero <= zeroNext;
            cmd.Cin <= cinNext;
            OutStrobe <= outNext;
        end
    end

    opWhileBusy: assert property (@(posedge Clk) disable iff (!Rst_n) OpValid |-> Ready)
        else $error("opcode issued while tape busy");

endmodule

`default_nettype wire

/* rtl/dekatronCounter.sv */
`default_nettype none

`include "dekatron_macros.svh"

module dekatronCounter
    import dekatronPkg::*;
#(
    parameter int DIGITS = 2,
    parameter bit TOP_LIMIT = 1'b0,
    parameter logic [DIGITS*`DEKATRON_WIDTH-1:0] TOP_VALUE = '0
) (
    input logic Clk,
    input logic Rst_n,
    counterIf.counter cnt
);

    localparam int width = DIGITS * `DEKATRON_WIDTH;
    localparam int busyBits = $clog2(`STEP_CYCLES + 1);

    logic [width-1:0] value;
    logic [width-1:0] pending;
    logic [width-1:0] stepped;
    logic [width-1:0] nextValue;
    logic [busyBits-1:0] busyCnt;
    logic accept;
    logic carry;
    logic allBcd;
    digitT stepDigit;
    digitT checkDigit;

    assign cnt.Ready = (busyCnt == '0);
    assign cnt.Out = value;
    assign cnt.Zero = (value == '0);
    assign accept = cnt.Request && cnt.Ready;

    // decimal carry or borrow ripples up from the lowest digit.
    always_comb begin
        carry = 1'b1;
        stepDigit = '0;
        stepped = value;
        for (int i = 0; i < DIGITS; i++) begin
            stepDigit = value[i*`DEKATRON_WIDTH +: `DEKATRON_WIDTH];
            if (carry) begin
                if (cnt.Dec) begin
                    carry = (stepDigit == digitT'(0));
                    stepped[i*`DEKATRON_WIDTH +: `DEKATRON_WIDTH] =
                        carry ? digitT'(9) : stepDigit - digitT'(1);
                end else begin
                    carry = (stepDigit == digitT'(9));
                    stepped[i*`DEKATRON_WIDTH +: `DEKATRON_WIDTH] =
                        carry ? digitT'(0) : stepDigit + digitT'(1);
                end
            end
        end
    end

    // clear beats load, load beats a step.
    always_comb begin
        if (cnt.SetZero) begin
            nextValue = '0;
        end else if (cnt.Set) begin
            nextValue = cnt.In;
        end else if (TOP_LIMIT && !cnt.Dec && value == TOP_VALUE) begin
            nextValue = '0;
        end else if (TOP_LIMIT && cnt.Dec && value == '0) begin
            nextValue = TOP_VALUE;
        end else begin
            nextValue = stepped;
        end
    end

    always_comb begin
        allBcd = 1'b1;
        checkDigit = '0;
        for (int i = 0; i < DIGITS; i++) begin
            checkDigit = value[i*`DEKATRON_WIDTH +: `DEKATRON_WIDTH];
            if (checkDigit > digitT'(9)) begin
                allBcd = 1'b0;
            end
        end
    end

    // the new value shows up when the busy period ends.
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            busyCnt <= '0;
            value <= '0;
        end else if (accept) begin
            busyCnt <= busyBits'(`STEP_CYCLES);
        end else if (busyCnt != '0) begin
            busyCnt <= busyCnt - 1'b1;
            if (busyCnt == busyBits'(1)) begin
                value <= pending;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            pending <= nextValue;
        end
    end

    requestWhileBusy: assert property (@(posedge Clk) disable iff (!Rst_n)
        cnt.Request |-> cnt.Ready)
        else $error("counter request while busy");

    digitsInRange: assert property (@(posedge Clk) disable iff (!Rst_n) allBcd)
        else $error("counter digit above 9");

endmodule

`default_nettype wire

/* rtl/dekatronIf.sv */
`default_nettype none

`include "dekatron_macros.svh"

// one-cycle command strobes with their qualifiers.
interface lineCmdIf;
    logic ApRequest;
    logic DataRequest;
    logic Dec;
    logic Zero;
    logic Cin;

    modport decoder (output ApRequest, DataRequest, Dec, Zero, Cin);
    modport line (input ApRequest, DataRequest, Dec, Zero, Cin);
endinterface

interface counterIf #(
    parameter int DIGITS = 2
);
    logic Request;
    logic Dec;
    logic Set;
    logic SetZero;
    logic [DIGITS*`DEKATRON_WIDTH-1:0] In;
    logic Ready;
    logic [DIGITS*`DEKATRON_WIDTH-1:0] Out;
    logic Zero;

    modport ctrl (output Request, Dec, Set, SetZero, In, input Ready, Out, Zero);
    modport counter (input Request, Dec, Set, SetZero, In, output Ready, Out, Zero);
endinterface

interface tapeRamIf
    import dekatronPkg::*;
();
    apAddrT Address;
    cellT DataIn;
    cellT DataOut;
    logic WE;

    modport line (output Address, DataIn, WE, input DataOut);
    modport ram (input Address, DataIn, WE, output DataOut);
endinterface

`default_nettype wire

/* rtl/dekatronPkg.sv */
`default_nettype none

`include "dekatron_macros.svh"

package dekatronPkg;

    typedef logic [`DEKATRON_WIDTH-1:0] digitT;

    // packed BCD, lowest digit in the low nibble.
    typedef logic [`AP_DIGITS*`DEKATRON_WIDTH-1:0] apAddrT;
    typedef logic [`DATA_DIGITS*`DEKATRON_WIDTH-1:0] cellT;

    typedef enum logic [2:0] {
        incPtr  = 3'd0,
        decPtr  = 3'd1,
        incCell = 3'd2,
        decCell = 3'd3,
        clrCell = 3'd4,
        inCell  = 3'd5,
        outCell = 3'd6
    } opcodeT;

    typedef enum logic [2:0] {
        idle,
        load,
        store,
        cin,
        count
    } lineStateT;

endpackage

`default_nettype wire

/* rtl/dekatronTape.sv */
`default_nettype none

module dekatronTape
    import dekatronPkg::*;
(
    input logic Clk,
    input logic Rst_n,
    input opcodeT Op,
    input logic OpValid,
    input cellT InData,
    output logic Ready,
    output logic OutValid,
    output logic DataZero,
    output logic ApZero,
    output cellT OutData
);

    lineCmdIf cmdBus ();
    tapeRamIf ramBus ();

    logic outStrobe;
    cellT txData;

    commandDecoder commandDecoder_i (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .Op(Op),
        .OpValid(OpValid),
        .Ready(Ready),
        .OutStrobe(outStrobe),
        .cmd(cmdBus.decoder)
    );

    apLine apLine_i (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .InData(InData),
        .cmd(cmdBus.line),
        .ram(ramBus.line),
        .Ready(Ready),
        .DataZero(DataZero),
        .ApZero(ApZero),
        .TxData(txData)
    );

    tapeMemory tapeMemory_i (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .ram(ramBus.ram)
    );

    outputPort outputPort_i (
        .Clk(Clk),
        .Rst_n(Rst_n),
        .OutStrobe(outStrobe),
        .TxData(txData),
        .OutData(OutData),
        .OutValid(OutValid)
    );

endmodule

`default_nettype wire

/* rtl/dekatron_macros.svh */
`ifndef DEKATRON_MACROS_SVH
`define DEKATRON_MACROS_SVH

// bits of one decimal digit.
`define DEKATRON_WIDTH 4

// digits of the tape pointer and of one cell.
`define AP_DIGITS 2
`define DATA_DIGITS 3

// largest cell value, counting wraps here.
`define DATA_TOP 255

`define TAPE_CELLS 100

// busy cycles of one counter operation.
`define STEP_CYCLES 4

`endif

/* rtl/outputPort.sv */
`default_nettype none

module outputPort
    import dekatronPkg::*;
(
    input logic Clk,
    input logic Rst_n,
    input logic OutStrobe,
    input cellT TxData,
    output cellT OutData,
    output logic OutValid
);

    // one valid pulse per output strobe.
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            OutValid <= 1'b0;
        end else begin
            OutValid <= OutStrobe;
        end
    end

    // held until the next output.
    always_ff @(posedge Clk) begin
        if (OutStrobe) begin
            OutData <= TxData;
        end
    end

endmodule

`default_nettype wire

/* rtl/tapeMemory.sv */
`default_nettype none

`include "dekatron_macros.svh"

module tapeMemory
    import dekatronPkg::*;
(
    input logic Clk,
    input logic Rst_n,
    tapeRamIf.ram ram
);

    cellT cells [`TAPE_CELLS];
    int unsigned index;
    logic dataIsBcd;
    digitT checkDigit;

    // BCD pointer to a plain cell number.
    always_comb begin
        index = 0;
        for (int i = `AP_DIGITS - 1; i >= 0; i--) begin
            index = index * 10 + 32'(ram.Address[i*`DEKATRON_WIDTH +: `DEKATRON_WIDTH]);
        end
    end

    always_comb begin
        dataIsBcd = 1'b1;
        checkDigit = '0;
        for (int i = 0; i < `DATA_DIGITS; i++) begin
            checkDigit = ram.DataIn[i*`DEKATRON_WIDTH +: `DEKATRON_WIDTH];
            if (checkDigit > digitT'(9)) begin
                dataIsBcd = 1'b0;
            end
        end
    end

    assign ram.DataOut = cells[index];

    // the tape starts blank.
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            for (int i = 0; i < `TAPE_CELLS; i++) begin
                cells[i] <= '0;
            end
        end else if (ram.WE) begin
            cells[index] <= ram.DataIn;
        end
    end

    bcdWrite: assert property (@(posedge Clk) disable iff (!Rst_n) ram.WE |-> dataIsBcd)
        else $error("non-BCD digit written to tape");

endmodule

`default_nettype wire
